//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = video_tb
FILELIST  = files.f
BUILD     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

//--- files.f
hdl/video_pkg.sv
hdl/mem_pkg.sv
hdl/video_sync.sv
hdl/pixel_fetch.sv
hdl/host_port.sv
hdl/mem_arbiter.sv
hdl/video_mem.sv
hdl/video_top.sv
testbench/video_chk.sv
testbench/video_tb.sv

//--- hdl/host_port.sv
`timescale 1ns/1ns
`default_nettype none

module host_port
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     host_req,
	input  wire mem_pkg::mem_req_t  host_pkt,
	input  wire                     ack,
	input  wire mem_pkg::mem_rsp_t  rsp,
	output logic                    host_ack,
	output mem_pkg::mem_rsp_t       host_rsp,
	output logic                    req,
	output mem_pkg::mem_req_t       pkt
);

	typedef enum logic [1:0] {st_idle, st_inner, st_drain, st_outer} host_state_t;

	host_state_t state;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= st_idle;
			req      <= 1'b0;
			host_ack <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (host_req)
					begin
						req   <= 1'b1;
						state <= st_inner;
					end
				st_inner:
					if (ack)
					begin
						req   <= 1'b0;
						state <= st_drain;
					end
				// outer ack only once the arbiter has let go
				st_drain:
					if (!ack)
					begin
						host_ack <= 1'b1;
						state    <= st_outer;
					end
				st_outer:
					if (!host_req)
					begin
						host_ack <= 1'b0;
						state    <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == st_idle) && host_req)
			pkt <= host_pkt;
		if ((state == st_inner) && ack)
			host_rsp <= rsp;
	end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     vid_req,
	input  wire mem_pkg::mem_req_t  vid_pkt,
	input  wire                     host_req,
	input  wire mem_pkg::mem_req_t  host_pkt,
	input  wire mem_pkg::mem_data_t mem_rdata,
	output logic                    vid_ack,
	output mem_pkg::mem_rsp_t       vid_rsp,
	output logic                    host_ack,
	output mem_pkg::mem_rsp_t       host_rsp,
	output logic                    mem_en,
	output logic                    mem_we,
	output mem_pkg::mem_addr_t      mem_addr,
	output mem_pkg::mem_data_t      mem_wdata
);

	import mem_pkg::*;

	typedef enum logic [1:0] {st_idle, st_access, st_ack} arb_state_t;

	arb_state_t state;
	logic       owner_host;
	logic       owner_req;
	mem_req_t   sel_pkt;

	assign sel_pkt   = owner_host ? host_pkt : vid_pkt;
	assign owner_req = owner_host ? host_req : vid_req;

	// memory is touched only in the access cycle
	assign mem_en    = (state == st_access);
	assign mem_we    = mem_en && sel_pkt.we;
	assign mem_addr  = sel_pkt.addr;
	assign mem_wdata = sel_pkt.wdata;

	// read data is held by the memory until the next access
	assign vid_rsp.rdata  = mem_rdata;
	assign host_rsp.rdata = mem_rdata;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state      <= st_idle;
			owner_host <= 1'b0;
			vid_ack    <= 1'b0;
			host_ack   <= 1'b0;
		end
		else
		begin
			case (state)
				// fetcher first
				st_idle:
					if (vid_req)
					begin
						owner_host <= 1'b0;
						state      <= st_access;
					end
					else if (host_req)
					begin
						owner_host <= 1'b1;
						state      <= st_access;
					end
				st_access:
				begin
					vid_ack  <= !owner_host;
					host_ack <= owner_host;
					state    <= st_ack;
				end
				st_ack:
					if (!owner_req)
					begin
						vid_ack  <= 1'b0;
						host_ack <= 1'b0;
						state    <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// word address is {row, column}
	localparam int row_w = 9;
	localparam int col_w = 8;
	localparam int addr_w = row_w + col_w;
	localparam int data_w = 16;
	localparam int mem_words = 2 ** addr_w;

	typedef logic [addr_w-1:0] mem_addr_t;
	typedef logic [data_w-1:0] mem_data_t;

	typedef struct packed
	{
		logic      we;
		mem_addr_t addr;
		mem_data_t wdata;
	} mem_req_t;

	typedef struct packed
	{
		mem_data_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/pixel_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     video_go,
	input  wire [7:0]               cnt_col,
	input  wire [8:0]               cnt_row,
	input  wire                     ack,
	input  wire mem_pkg::mem_rsp_t  rsp,
	output logic                    req,
	output mem_pkg::mem_req_t       pkt,
	output logic                    col_step,
	output mem_pkg::mem_data_t      px_data,
	output logic                    px_valid
);

	import mem_pkg::*;

	typedef enum logic [1:0] {st_idle, st_wait, st_release} fetch_state_t;

	fetch_state_t state;
	mem_addr_t    fetch_addr;

	assign fetch_addr = {cnt_row, cnt_col};

	// advance only when the word is kept
	assign col_step = (state == st_wait) && ack && video_go;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= st_idle;
			req      <= 1'b0;
			px_valid <= 1'b0;
		end
		else
		begin
			px_valid <= 1'b0;
			case (state)
				st_idle:
					if (video_go)
					begin
						req   <= 1'b1;
						state <= st_wait;
					end
				st_wait:
					if (ack)
					begin
						req      <= 1'b0;
						// word is dropped once the window has closed
						px_valid <= video_go;
						state    <= st_release;
					end
				st_release:
					if (!ack)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == st_idle) && video_go)
			pkt <= '{we: 1'b0, addr: fetch_addr, wdata: '0};
		if ((state == st_wait) && ack)
			px_data <= rsp.rdata;
	end

endmodule

`default_nettype wire

//--- hdl/video_mem.sv
`timescale 1ns/1ns
`default_nettype none

module video_mem
(
	input  wire                     clk,
	input  wire                     en,
	input  wire                     we,
	input  wire mem_pkg::mem_addr_t addr,
	input  wire mem_pkg::mem_data_t wdata,
	output mem_pkg::mem_data_t      rdata
);

	import mem_pkg::*;

	mem_data_t mem [0:mem_words-1];

	// rdata keeps the last word read
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

	// pixel window, fetch lead and interrupt position
	// horizontal values are in pixel strobes, vertical values in lines
	typedef struct packed
	{
		logic [8:0] hpix_beg;
		logic [8:0] hpix_end;
		logic [8:0] vpix_beg;
		logic [8:0] vpix_end;
		logic [4:0] go_offs;
		logic [7:0] hint_beg;
		logic [8:0] vint_beg;
		logic [7:0] cstart;
		logic [8:0] rstart;
	} raster_cfg_t;

	// registered raster outputs
	typedef struct packed
	{
		logic hsync;
		logic vsync;
		logic csync;
		logic tv_blank;
		logic hvpix;
	} sync_out_t;

endpackage

`default_nettype wire

//--- hdl/video_sync.sv
`timescale 1ns/1ns
`default_nettype none

module video_sync
#(
	parameter int h_period      = 448,
	parameter int v_period_50   = 320,
	parameter int v_period_60   = 262,
	parameter int vblank_end_50 = 32,
	parameter int vblank_end_60 = 22,
	parameter int hsync_beg     = 11,
	parameter int hsync_end     = 43,
	parameter int vsync_beg_50  = 8,
	parameter int vsync_end_50  = 11,
	parameter int vsync_beg_60  = 4,
	parameter int vsync_end_60  = 7
)
(
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire video_pkg::raster_cfg_t  cfg,
	input  wire                          cfg_60hz,
	input  wire                          sync_pol,
	input  wire                          nogfx,
	input  wire                          col_step,
	output video_pkg::sync_out_t         sync,
	output logic                         v60hz,
	output logic                         frame_start,
	output logic                         int_start,
	output logic                         flash,
	output logic                         video_go,
	output logic [7:0]                   cnt_col,
	output logic [8:0]                   cnt_row
);

	import video_pkg::*;

	localparam logic [8:0] h_last = 9'(h_period - 1);
	localparam logic [8:0] hs_beg = 9'(hsync_beg);
	localparam logic [8:0] hs_end = 9'(hsync_end);
	// front porch, sync and back porch
	localparam logic [8:0] hblank_end = 9'(2 * hsync_end + 2);

	logic [1:0] pix_div;
	logic       pix_stb;
	logic [8:0] hcount;
	logic [8:0] vcount;
	logic [4:0] flash_ctr;
	logic [8:0] v_last;
	logic [8:0] vs_beg;
	logic [8:0] vs_end;
	logic [8:0] vblank_end;
	logic       line_last;
	logic       line_end;
	logic       frame_last;
	logic       vis_start;
	logic       col_reload;
	logic       hs;
	logic       vs;
	logic       hpix;
	logic       vpix;
	logic [8:0] go_beg;
	logic [8:0] go_end;
	sync_out_t  sync_d;

	// vertical timing follows the latched mode
	assign v_last     = v60hz ? 9'(v_period_60 - 1) : 9'(v_period_50 - 1);
	assign vs_beg     = v60hz ? 9'(vsync_beg_60) : 9'(vsync_beg_50);
	assign vs_end     = v60hz ? 9'(vsync_end_60) : 9'(vsync_end_50);
	assign vblank_end = v60hz ? 9'(vblank_end_60) : 9'(vblank_end_50);

	// one pixel strobe every four clocks
	assign pix_stb = (pix_div == 2'd3);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pix_div <= 2'd0;
		else
			pix_div <= pix_div + 2'd1;
	end

	assign line_last   = (hcount == h_last);
	assign frame_last  = (vcount == v_last);
	assign line_end    = pix_stb && line_last;
	assign frame_start = line_end && frame_last;
	assign vis_start   = line_end && (vcount == vblank_end - 9'd1);
	assign col_reload  = pix_stb && (hcount == hs_end - 9'd1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcount <= 9'd0;
			vcount <= 9'd0;
		end
		else if (pix_stb)
		begin
			hcount <= line_last ? 9'd0 : hcount + 9'd1;
			if (line_last)
				vcount <= frame_last ? 9'd0 : vcount + 9'd1;
		end
	end

	// mode re-sync and flash counter step once per frame
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v60hz     <= 1'b0;
			flash_ctr <= 5'd0;
		end
		else if (frame_start)
		begin
			v60hz     <= cfg_60hz;
			flash_ctr <= flash_ctr + 5'd1;
		end
	end

	assign flash = flash_ctr[4];

	// hint_beg counts in pairs of pixels
	assign int_start = pix_stb && (hcount == {cfg.hint_beg, 1'b0}) &&
		(vcount == cfg.vint_beg);

	// dram column reloads at hsync end
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt_col <= 8'd0;
		else if (col_reload)
			cnt_col <= cfg.cstart;
		else if (col_step)
			cnt_col <= cnt_col + 8'd1;
	end

	// dram row
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt_row <= 9'd0;
		else if (vis_start)
			cnt_row <= cfg.rstart;
		else if (line_end && vpix)
			cnt_row <= cnt_row + 9'd1;
	end

	assign hs   = (hcount >= hs_beg) && (hcount < hs_end);
	assign vs   = (vcount >= vs_beg) && (vcount < vs_end);
	assign hpix = (hcount >= cfg.hpix_beg) && (hcount < cfg.hpix_end);
	assign vpix = (vcount >= cfg.vpix_beg) && (vcount < cfg.vpix_end);

	// fetch window leads the pixel window by go_offs
	assign go_beg = cfg.hpix_beg - {4'd0, cfg.go_offs};
	assign go_end = cfg.hpix_end - {4'd0, cfg.go_offs};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			video_go <= 1'b0;
		else
			video_go <= (hcount >= go_beg) && (hcount < go_end) && vpix && !nogfx;
	end

	always_comb
	begin
		sync_d.hsync    = sync_pol ^ hs;
		sync_d.vsync    = sync_pol ^ vs;
		sync_d.csync    = ~(hs ^ vs);
		sync_d.tv_blank = (hcount < hblank_end) || (vcount < vblank_end);
		sync_d.hvpix    = hpix && vpix;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sync.hsync    <= sync_pol;
			sync.vsync    <= sync_pol;
			sync.csync    <= 1'b1;
			sync.tv_blank <= 1'b1;
			sync.hvpix    <= 1'b0;
		end
		else
			sync <= sync_d;
	end

endmodule

`default_nettype wire

//--- hdl/video_top.sv
`timescale 1ns/1ns
`default_nettype none

module video_top
#(
	parameter int h_period      = 448,
	parameter int v_period_50   = 320,
	parameter int v_period_60   = 262,
	parameter int vblank_end_50 = 32,
	parameter int vblank_end_60 = 22,
	parameter int hsync_beg     = 11,
	parameter int hsync_end     = 43,
	parameter int vsync_beg_50  = 8,
	parameter int vsync_end_50  = 11,
	parameter int vsync_beg_60  = 4,
	parameter int vsync_end_60  = 7
)
(
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire video_pkg::raster_cfg_t  cfg,
	input  wire                          cfg_60hz,
	input  wire                          sync_pol,
	input  wire                          nogfx,
	input  wire                          host_req,
	input  wire mem_pkg::mem_req_t       host_pkt,
	output wire                          host_ack,
	output wire mem_pkg::mem_rsp_t       host_rsp,
	output wire video_pkg::sync_out_t    sync,
	output wire                          v60hz,
	output wire                          frame_start,
	output wire                          int_start,
	output wire                          flash,
	output wire mem_pkg::mem_data_t      px_data,
	output wire                          px_valid
);

	import mem_pkg::*;

	wire            video_go;
	wire [7:0]      cnt_col;
	wire [8:0]      cnt_row;
	wire            col_step;
	wire            vid_req;
	wire mem_req_t  vid_pkt;
	wire            vid_ack;
	wire mem_rsp_t  vid_rsp;
	wire            hp_req;
	wire mem_req_t  hp_pkt;
	wire            hp_ack;
	wire mem_rsp_t  hp_rsp;
	wire            mem_en;
	wire            mem_we;
	wire mem_addr_t mem_addr;
	wire mem_data_t mem_wdata;
	wire mem_data_t mem_rdata;

	video_sync
	#(
		.h_period      (h_period),
		.v_period_50   (v_period_50),
		.v_period_60   (v_period_60),
		.vblank_end_50 (vblank_end_50),
		.vblank_end_60 (vblank_end_60),
		.hsync_beg     (hsync_beg),
		.hsync_end     (hsync_end),
		.vsync_beg_50  (vsync_beg_50),
		.vsync_end_50  (vsync_end_50),
		.vsync_beg_60  (vsync_beg_60),
		.vsync_end_60  (vsync_end_60)
	)
	u_sync
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg         (cfg),
		.cfg_60hz    (cfg_60hz),
		.sync_pol    (sync_pol),
		.nogfx       (nogfx),
		.col_step    (col_step),
		.sync        (sync),
		.v60hz       (v60hz),
		.frame_start (frame_start),
		.int_start   (int_start),
		.flash       (flash),
		.video_go    (video_go),
		.cnt_col     (cnt_col),
		.cnt_row     (cnt_row)
	);

	pixel_fetch u_fetch
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.video_go (video_go),
		.cnt_col  (cnt_col),
		.cnt_row  (cnt_row),
		.ack      (vid_ack),
		.rsp      (vid_rsp),
		.req      (vid_req),
		.pkt      (vid_pkt),
		.col_step (col_step),
		.px_data  (px_data),
		.px_valid (px_valid)
	);

	host_port u_host
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.host_req (host_req),
		.host_pkt (host_pkt),
		.ack      (hp_ack),
		.rsp      (hp_rsp),
		.host_ack (host_ack),
		.host_rsp (host_rsp),
		.req      (hp_req),
		.pkt      (hp_pkt)
	);

	mem_arbiter u_arb
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.vid_req   (vid_req),
		.vid_pkt   (vid_pkt),
		.host_req  (hp_req),
		.host_pkt  (hp_pkt),
		.mem_rdata (mem_rdata),
		.vid_ack   (vid_ack),
		.vid_rsp   (vid_rsp),
		.host_ack  (hp_ack),
		.host_rsp  (hp_rsp),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	video_mem u_mem
	(
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- testbench/video_chk.sv
`timescale 1ns/1ns
`default_nettype none

module video_chk
(
	input wire clk,
	input wire rst_n,
	input wire vid_req,
	input wire vid_ack,
	input wire host_req,
	input wire host_ack
);

	int n_fail;

	initial
		n_fail = 0;

	// ack rises only on a pending request
	a_vid_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(vid_ack) |-> vid_req)
		else
		begin
			$error("fetch ack raised without a fetch request");
			n_fail = n_fail + 1;
		end

	a_host_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(host_ack) |-> host_req)
		else
		begin
			$error("host ack raised without a host request");
			n_fail = n_fail + 1;
		end

	// requests are held until acknowledged
	a_vid_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(vid_req) |-> vid_ack)
		else
		begin
			$error("fetch request dropped before its ack");
			n_fail = n_fail + 1;
		end

	a_host_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(host_req) |-> host_ack)
		else
		begin
			$error("host request dropped before its ack");
			n_fail = n_fail + 1;
		end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(vid_ack && host_ack))
		else
		begin
			$error("both acks high together");
			n_fail = n_fail + 1;
		end

endmodule

bind mem_arbiter video_chk u_chk
(
	.clk      (clk),
	.rst_n    (rst_n),
	.vid_req  (vid_req),
	.vid_ack  (vid_ack),
	.host_req (host_req),
	.host_ack (host_ack)
);

`default_nettype wire

//--- testbench/video_stim.txt
# op addr data: W host write, R host read with expected data
# F expected fetched word on the first visible line, in column order
W 00410 a5c3
W 00411 1e2f
W 00412 7b00
W 00413 0c9d
W 00414 f00f
W 00415 3456
R 00412 7b00
W 1ff80 beef
R 1ff80 beef
R 00410 a5c3
R 00415 3456
F 00410 a5c3
F 00411 1e2f
F 00412 7b00
F 00413 0c9d
F 00414 f00f
F 00415 3456

//--- testbench/video_tb.sv
`timescale 1ns/1ns
`default_nettype none

module video_tb;

	import video_pkg::*;
	import mem_pkg::*;

	// short raster
	localparam int h_p = 64;
	localparam int v50 = 20;
	localparam int v60 = 16;
	localparam int vb50 = 4;
	localparam int hs_b = 2;
	localparam int hs_e = 8;
	localparam int frame_clks = h_p * 4 * v50;
	localparam int clk_ns = 40;

	logic        clk;
	logic        rst_n;
	raster_cfg_t cfg;
	logic        cfg_60hz;
	logic        sync_pol;
	logic        nogfx;
	logic        host_req;
	mem_req_t    host_pkt;
	wire         host_ack;
	mem_rsp_t    host_rsp;
	sync_out_t   sync;
	wire         v60hz;
	wire         frame_start;
	wire         int_start;
	wire         flash;
	mem_data_t   px_data;
	wire         px_valid;

	byte         op_q[$];
	mem_addr_t   addr_q[$];
	mem_data_t   data_q[$];
	mem_addr_t   f_addr[$];
	mem_data_t   f_data[$];
	logic [2:0]  frame_a [0:frame_clks-1];
	logic [31:0] lfsr;
	longint      cyc;
	int          errors;
	int          test_errs;
	int          passed;
	int          failed;
	logic        stim_loaded;
	longint      watch_ns;

	video_top
	#(
		.h_period      (h_p),
		.v_period_50   (v50),
		.v_period_60   (v60),
		.vblank_end_50 (vb50),
		.vblank_end_60 (3),
		.hsync_beg     (hs_b),
		.hsync_end     (hs_e),
		.vsync_beg_50  (1),
		.vsync_end_50  (3),
		.vsync_beg_60  (1),
		.vsync_end_60  (2)
	)
	UUT
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg         (cfg),
		.cfg_60hz    (cfg_60hz),
		.sync_pol    (sync_pol),
		.nogfx       (nogfx),
		.host_req    (host_req),
		.host_pkt    (host_pkt),
		.host_ack    (host_ack),
		.host_rsp    (host_rsp),
		.sync        (sync),
		.v60hz       (v60hz),
		.frame_start (frame_start),
		.int_start   (int_start),
		.flash       (flash),
		.px_data     (px_data),
		.px_valid    (px_valid)
	);

	initial
		clk = 1'b0;

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %0h, actual %0h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic fail_msg(input string text);
		$display("%s", text);
		errors++;
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			$display("PASS %s", name);
			passed++;
		end
		else
		begin
			$display("FAIL %s, %0d errors", name, test_errs);
			failed++;
		end
		test_errs = 0;
	endtask

	task automatic load_stim(output logic ok);
		int fd;
		int n;
		string line;
		byte op;
		logic [31:0] a;
		logic [31:0] d;
		ok = 1'b0;
		fd = $fopen("testbench/video_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 2 && line[0] != 8'h23)
				begin
					n = $sscanf(line, "%c %h %h", op, a, d);
					if (op == "F")
					begin
						f_addr.push_back(mem_addr_t'(a));
						f_data.push_back(mem_data_t'(d));
					end
					else
					begin
						op_q.push_back(op);
						addr_q.push_back(mem_addr_t'(a));
						data_q.push_back(mem_data_t'(d));
					end
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// four-phase host cycle as seen from outside the top level
	task automatic host_access(input logic we, input mem_addr_t addr,
		input mem_data_t wdata, output mem_data_t rdata, output logic busy);
		@(posedge clk);
		host_req <= 1'b1;
		host_pkt <= '{we: we, addr: addr, wdata: wdata};
		busy = 1'b0;
		@(negedge clk);
		while (!host_ack)
		begin
			if (px_valid)
				busy = 1'b1;
			@(negedge clk);
		end
		rdata = host_rsp.rdata;
		@(posedge clk);
		host_req <= 1'b0;
		@(negedge clk);
		while (host_ack)
			@(negedge clk);
	endtask

	// ends on the negedge that sees frame_start
	task automatic wait_frame();
		@(negedge clk);
		while (!frame_start)
			@(negedge clk);
	endtask

	// one whole frame between two frame_start strobes
	task automatic run_frame(output int n_int, output int n_px, output logic fl);
		n_int = 0;
		n_px = 0;
		@(negedge clk);
		fl = flash;
		while (!frame_start)
		begin
			if (int_start)
				n_int++;
			if (px_valid)
				n_px++;
			@(negedge clk);
		end
	endtask

	task automatic test_period();
		longint t0;
		int ni;
		int np;
		logic fl;
		wait_frame();
		t0 = cyc;
		run_frame(ni, np, fl);
		check_val("raster_period 50hz", 32'(frame_clks), 32'(cyc - t0));
		@(posedge clk);
		cfg_60hz <= 1'b1;
		wait_frame();
		t0 = cyc;
		run_frame(ni, np, fl);
		check_val("raster_period 60hz", 32'(h_p * 4 * v60), 32'(cyc - t0));
		check_val("raster_period v60hz", 32'd1, 32'(v60hz));
		@(posedge clk);
		cfg_60hz <= 1'b0;
		wait_frame();
		finish_test("raster_period");
	endtask

	task automatic test_host_rw();
		int i;
		int sp;
		mem_data_t rd;
		logic busy;
		for (i = 0; i < op_q.size(); i++)
		begin
			sp = take_bits(8);
			repeat (sp) @(posedge clk);
			host_access(op_q[i] == "W", addr_q[i], data_q[i], rd, busy);
			if (op_q[i] == "R")
				check_val("host_rw", 32'(data_q[i]), 32'(rd));
		end
		finish_test("host_rw");
	endtask

	task automatic test_display();
		int k;
		int ni;
		int np;
		logic fl;
		wait_frame();
		k = 0;
		while (k < f_data.size())
		begin
			@(negedge clk);
			if (frame_start)
			begin
				fail_msg("display_fetch: frame ended before all words were fetched");
				k = f_data.size();
			end
			else if (px_valid)
			begin
				check_val("display_fetch", 32'(f_data[k]), 32'(px_data));
				k++;
			end
		end
		@(posedge clk);
		nogfx <= 1'b1;
		wait_frame();
		run_frame(ni, np, fl);
		check_val("display_fetch nogfx", 32'd0, 32'(np));
		@(posedge clk);
		nogfx <= 1'b0;
		finish_test("display_fetch");
	endtask

	task automatic test_contention();
		int tries;
		int n_busy;
		int idx;
		int sp;
		mem_data_t rd;
		logic busy;
		tries = 0;
		n_busy = 0;
		while (tries < 200 && n_busy < 4)
		begin
			idx = take_bits(3) % f_addr.size();
			sp = take_bits(8);
			repeat (sp) @(posedge clk);
			host_access(1'b0, f_addr[idx], '0, rd, busy);
			check_val("contention", 32'(f_data[idx]), 32'(rd));
			if (busy)
				n_busy++;
			tries++;
		end
		if (n_busy < 4)
			fail_msg("contention: too few host accesses overlapped the fetcher");
		finish_test("contention");
	endtask

	task automatic test_sync();
		int i;
		int cnt;
		int n_pix;
		int n_overlap;
		int n_blank;
		logic [2:0] cur;
		wait_frame();
		cnt = 0;
		n_pix = 0;
		n_overlap = 0;
		n_blank = 0;
		for (i = 0; i < frame_clks; i++)
		begin
			frame_a[i] = {sync.hsync, sync.vsync, sync.csync};
			if (sync.hsync != sync_pol)
				cnt++;
			if (sync.hvpix)
				n_pix++;
			if (sync.hvpix && sync.tv_blank)
				n_overlap++;
			if (sync.tv_blank)
				n_blank++;
			@(negedge clk);
		end
		// four clocks per pixel strobe
		check_val("sync_shape hsync width", 32'((hs_e - hs_b) * 4 * v50), 32'(cnt));
		check_val("sync_shape pixel window",
			32'((int'(cfg.hpix_end) - int'(cfg.hpix_beg)) *
			(int'(cfg.vpix_end) - int'(cfg.vpix_beg)) * 4), 32'(n_pix));
		check_val("sync_shape blank inside pixel window", 32'd0, 32'(n_overlap));
		if (n_blank < vb50 * h_p * 4)
			fail_msg("sync_shape: blank shorter than the vertical blanking lines");
		@(posedge clk);
		sync_pol <= 1'b1;
		wait_frame();
		for (i = 0; i < frame_clks; i++)
		begin
			cur = {sync.hsync, sync.vsync, sync.csync};
			if (cur !== {~frame_a[i][2], ~frame_a[i][1], frame_a[i][0]})
			begin
				check_val("sync_shape polarity", 32'({~frame_a[i][2],
					~frame_a[i][1], frame_a[i][0]}), 32'(cur));
				i = frame_clks;
			end
			@(negedge clk);
		end
		@(posedge clk);
		sync_pol <= 1'b0;
		finish_test("sync_shape");
	endtask

	task automatic test_int_flash();
		int f;
		int ni;
		int np;
		int first;
		int second;
		logic fl;
		logic prev;
		first = -1;
		second = -1;
		wait_frame();
		run_frame(ni, np, prev);
		for (f = 1; f < 36 && second < 0; f++)
		begin
			run_frame(ni, np, fl);
			check_val("int_flash interrupts per frame", 32'd1, 32'(ni));
			if (fl != prev)
			begin
				if (first < 0)
					first = f;
				else
					second = f;
			end
			prev = fl;
		end
		if (second < 0)
			fail_msg("int_flash: flash did not toggle twice");
		else
			check_val("int_flash toggle spacing", 32'd16, 32'(second - first));
		finish_test("int_flash");
	endtask

	initial
	begin
		stim_loaded = 1'b0;
		wait (stim_loaded);
		watch_ns = (longint'(70) * frame_clks + longint'(op_q.size() + 250) * 400) * clk_ns;
		#(watch_ns);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		logic ok;
		cyc = 0;
		errors = 0;
		test_errs = 0;
		passed = 0;
		failed = 0;
		lfsr = 32'hcf16_8e34;
		rst_n = 1'b0;
		cfg_60hz = 1'b0;
		sync_pol = 1'b0;
		nogfx = 1'b0;
		host_req = 1'b0;
		host_pkt = '0;
		cfg = '{hpix_beg: 9'd24, hpix_end: 9'd56, vpix_beg: 9'd4, vpix_end: 9'd14,
			go_offs: 5'd4, hint_beg: 8'd10, vint_beg: 9'd2, cstart: 8'h10,
			rstart: 9'd4};
		load_stim(ok);
		if (!ok)
		begin
			$display("could not open the stimulus file");
			$display("Test FAILED");
			$finish;
		end
		else
		begin
			stim_loaded = 1'b1;
			repeat (10) @(posedge clk);
			rst_n <= 1'b1;
			test_period();
			test_host_rw();
			test_display();
			test_contention();
			test_sync();
			test_int_flash();
			if (UUT.u_arb.u_chk.n_fail != 0)
				fail_msg("handshake assertions failed during the run");
			finish_test("handshake");
			$display("tests run %0d, passed %0d, failed %0d, errors %0d",
				passed + failed, passed, failed, errors);
			if (errors == 0 && failed == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire
